// File: dv/wb_tb.sv
`timescale 1ns/1ps
`include "wb_params.svh"

module wb_tb import wb_pkg::*; ();

	localparam int ALU_REQS      = 6;
	localparam int MOVEI_REQS    = 6;
	localparam int LOAD_REQS     = 32;
	localparam int MIXED_REQS    = 6;
	localparam int BURST_REQS    = 8;
	localparam int SETTLE_CYCLES = 8;
	localparam int TOTAL_REQS    = 2 * ALU_REQS + MOVEI_REQS + 2 * LOAD_REQS
		+ 4 * MIXED_REQS + 4 * BURST_REQS;
	localparam int TIMEOUT_CYCLES = TOTAL_REQS * 4 + 200;

	// Expected thread id kept beside each result
	typedef struct packed {
		thread_id_t thread_id;
		wb_result_t result;
	} expected_t;

	logic        clk;
	logic        reset;
	logic        src_valid [`WB_NUM_PIPES];
	wb_request_t src_req [`WB_NUM_PIPES];
	pipe_vec_t   wb_fifo_full;
	logic        wb_valid;
	thread_id_t  wb_thread_id;
	wb_result_t  wb_result;

	expected_t exp_q [`WB_NUM_PIPES][$];
	int        seq_num [`WB_NUM_PIPES];
	int        seed = 32'ha522c5d9;
	int        errors = 0;
	int        test_start_errors = 0;
	int        out_count = 0;
	int        expected_count = 0;
	bit        full_seen = 0;

	writeback_top dut_i (
		.clk          (clk),
		.reset        (reset),
		.fp_valid     (src_valid[PIPE_FP]),
		.fp_req       (src_req[PIPE_FP]),
		.int_valid    (src_valid[PIPE_INT]),
		.int_req      (src_req[PIPE_INT]),
		.spm_valid    (src_valid[PIPE_SPM]),
		.spm_req      (src_req[PIPE_SPM]),
		.mem_valid    (src_valid[PIPE_MEM]),
		.mem_req      (src_req[PIPE_MEM]),
		.wb_fifo_full (wb_fifo_full),
		.wb_valid     (wb_valid),
		.wb_thread_id (wb_thread_id),
		.wb_result    (wb_result)
	);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	// Byte or halfword pick with extension, size in bytes
	function automatic logic [31:0] extend_lane(input logic [31:0] word, input int size,
			input bit sgn, input logic [1:0] byte_sel);
		logic [31:0] shifted;
		if (size == 4)
			return word;
		if (size == 1) begin
			shifted = word >> (8 * byte_sel);
			return sgn ? {{24{shifted[7]}}, shifted[7:0]} : {24'h0, shifted[7:0]};
		end
		shifted = word >> (16 * byte_sel[1]);
		return sgn ? {{16{shifted[15]}}, shifted[15:0]} : {16'h0, shifted[15:0]};
	endfunction

	function automatic wb_result_t expected_result(input wb_request_t r, input pipe_id_t p);
		wb_result_t res;
		int         size;
		bit         sgn;
		bit         vec;
		res.pc          = r.pc;
		res.destination = r.destination;
		res.is_scalar   = ~r.is_destination_vector;
		res.lane_mask   = r.lane_mask;
		case (r.opcode)
			MOVEI_L: res.byte_enable = 4'b0011;
			MOVEI_H: res.byte_enable = 4'b1100;
			default: res.byte_enable = 4'b1111;
		endcase
		res.data = '0;
		if (p == PIPE_FP || p == PIPE_INT) begin
			res.data = r.result;
		end else if (r.opcode < MOVEI) begin
			sgn = r.opcode inside {LOAD_8, LOAD_16, LOAD_V_8, LOAD_V_16};
			vec = r.opcode inside {LOAD_V_8, LOAD_V_16, LOAD_V_32, LOAD_V_8_U, LOAD_V_16_U};
			if (r.opcode inside {LOAD_8, LOAD_8_U, LOAD_V_8, LOAD_V_8_U})
				size = 1;
			else if (r.opcode inside {LOAD_16, LOAD_16_U, LOAD_V_16, LOAD_V_16_U})
				size = 2;
			else
				size = 4;
			if (vec) begin
				for (int j = 0; j < `WB_HW_LANES; j++)
					res.data[j] = extend_lane(r.result[j], size, sgn, r.offset[1:0]);
			end else begin
				// Scalar load, chosen lane goes to lane 0
				res.data[0] = extend_lane(r.result[r.offset[3:2]], size, sgn, r.offset[1:0]);
			end
		end
		return res;
	endfunction

	// Pipe id in the top pc bits, sequence number below
	function automatic wb_request_t make_request(input pipe_id_t p, input wb_opcode_t op,
			input logic has_dest);
		wb_request_t r;
		r.pc        = {p, (`WB_PC_BITS-2)'(seq_num[p])};
		seq_num[p]  = seq_num[p] + 1;
		r.thread_id = thread_id_t'($random(seed));
		for (int j = 0; j < `WB_HW_LANES; j++)
			r.result[j] = $random(seed);
		r.lane_mask             = lane_mask_t'($random(seed));
		r.offset                = load_offset_t'($random(seed));
		r.destination           = reg_addr_t'($random(seed));
		r.has_destination       = has_dest;
		r.is_destination_vector = 1'($random(seed));
		r.opcode                = op;
		return r;
	endfunction

	function automatic wb_opcode_t default_op(input pipe_id_t p);
		if (p == PIPE_FP || p == PIPE_INT)
			return OP_ALU;
		return wb_opcode_t'($unsigned($random(seed)) % 10);
	endfunction

	function automatic bit scoreboard_empty();
		for (int p = 0; p < `WB_NUM_PIPES; p++)
			if (exp_q[p].size() != 0)
				return 1'b0;
		return 1'b1;
	endfunction

	task automatic check_result(input wb_result_t got, input wb_result_t exp, input string what);
		if (got !== exp) begin
			errors++;
			$display("error at %0t ns: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_thread(input thread_id_t got, input thread_id_t exp, input string what);
		if (got !== exp) begin
			errors++;
			$display("error at %0t ns: %s got %0d expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic check_flags(input pipe_vec_t got, input pipe_vec_t exp, input string what);
		if (got !== exp) begin
			errors++;
			$display("error at %0t ns: %s got %b expected %b", $time, what, got, exp);
		end
	endtask

	// Called at drive time, holds the request for one edge
	task automatic send(input wb_request_t r);
		int        p;
		expected_t e;
		p = int'(r.pc[`WB_PC_BITS-1 -: 2]);
		// Source stops while its FIFO reports almost full
		while (wb_fifo_full[p] === 1'b1) begin
			@(posedge clk);
			#1;
		end
		src_valid[p] = 1'b1;
		src_req[p]   = r;
		if (r.has_destination) begin
			e.thread_id = r.thread_id;
			e.result    = expected_result(r, pipe_id_t'(p));
			exp_q[p].push_back(e);
			expected_count++;
		end
		@(posedge clk);
		#1;
		src_valid[p] = 1'b0;
	endtask

	task automatic send_many(input pipe_id_t p, input int n);
		for (int i = 0; i < n; i++)
			send(make_request(p, default_op(p), 1'b1));
	endtask

	// Walks opcodes and offsets together so both get covered
	task automatic send_load_sweep(input pipe_id_t p, input int n);
		wb_request_t r;
		for (int i = 0; i < n; i++) begin
			r        = make_request(p, wb_opcode_t'(i % 10), 1'b1);
			r.offset = load_offset_t'(i);
			send(r);
		end
	endtask

	// Last request of the stream always has a destination
	task automatic send_mixed(input pipe_id_t p, input int n);
		for (int i = 0; i < n; i++)
			send(make_request(p, default_op(p), logic'(i % 3 != 1)));
	endtask

	task automatic finish_test(input string name);
		while (!scoreboard_empty())
			@(negedge clk);
		repeat (SETTLE_CYCLES) @(negedge clk);
		if (out_count != expected_count) begin
			errors++;
			$display("error at %0t ns: %0d outputs for %0d requests with a destination",
				$time, out_count, expected_count);
		end
		$display("test %s finished with %0d errors", name, errors - test_start_errors);
		test_start_errors = errors;
		@(posedge clk);
		#1;
	endtask

	// Outputs are registered, sampled on the falling edge
	always @(negedge clk) begin : compare_outputs
		expected_t exp;
		int        p;
		if (reset === 1'b0 && wb_valid === 1'b1) begin
			out_count++;
			p = int'(wb_result.pc[`WB_PC_BITS-1 -: 2]);
			if (exp_q[p].size() == 0) begin
				errors++;
				$display("unexpected output at %0t ns with pc %h, nothing outstanding on pipe %0d",
					$time, wb_result.pc, p);
			end else begin
				exp = exp_q[p].pop_front();
				check_result(wb_result, exp.result, "wb_result");
				check_thread(wb_thread_id, exp.thread_id, "wb_thread_id");
			end
		end
	end

	always @(negedge clk)
		if (|wb_fifo_full)
			full_seen = 1'b1;

	initial begin : watchdog
		repeat (TIMEOUT_CYCLES) @(posedge clk);
		$display("timeout after %0d cycles, the outputs stopped arriving", TIMEOUT_CYCLES);
		$display(">>> FAIL");
		$finish;
	end

	initial begin
		reset = 1'b1;
		for (int p = 0; p < `WB_NUM_PIPES; p++) begin
			src_valid[p] = 1'b0;
			src_req[p]   = '0;
			seq_num[p]   = 0;
		end
		repeat (10) @(posedge clk);
		#1;
		reset = 1'b0;

		// Idle state after reset, then plain ALU results
		check_flags(pipe_vec_t'(wb_valid), '0, "wb_valid after reset");
		check_flags(wb_fifo_full, '0, "wb_fifo_full after reset");
		fork
			send_many(PIPE_FP, ALU_REQS);
			send_many(PIPE_INT, ALU_REQS);
		join
		finish_test("alu_passthrough");

		for (int i = 0; i < MOVEI_REQS; i++)
			send(make_request(PIPE_INT, wb_opcode_t'(MOVEI + i % 3), 1'b1));
		finish_test("movei_byte_enable");

		fork
			send_load_sweep(PIPE_SPM, LOAD_REQS);
			send_load_sweep(PIPE_MEM, LOAD_REQS);
		join
		finish_test("load_format");

		fork
			send_mixed(PIPE_FP, MIXED_REQS);
			send_mixed(PIPE_INT, MIXED_REQS);
			send_mixed(PIPE_SPM, MIXED_REQS);
			send_mixed(PIPE_MEM, MIXED_REQS);
		join
		finish_test("no_destination");

		full_seen = 1'b0;
		fork
			send_many(PIPE_FP, BURST_REQS);
			send_many(PIPE_INT, BURST_REQS);
			send_many(PIPE_SPM, BURST_REQS);
			send_many(PIPE_MEM, BURST_REQS);
		join
		finish_test("burst_backpressure");
		if (!full_seen) begin
			errors++;
			$display("no wb_fifo_full bit rose during the four-pipe burst");
		end
		check_flags(wb_fifo_full, '0, "wb_fifo_full when idle");

		$display("%0d outputs checked, %0d errors", out_count, errors);
		if (errors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

// File: source/load_formatter.sv
`timescale 1ns/1ps
`include "wb_params.svh"

module load_formatter import wb_pkg::*; (
	input  wb_opcode_t   opcode,
	input  load_offset_t offset,
	input  lane_data_t   raw,
	output lane_data_t   formatted
);

	localparam int PAD8  = `WB_REG_BITS - 8;
	localparam int PAD16 = `WB_REG_BITS - 16;

	// Per-lane candidates, s = sign extended, u = zero extended
	lane_data_t byte_s;
	lane_data_t byte_u;
	lane_data_t half_s;
	lane_data_t half_u;
	lane_data_t word_v;

	// Lane that a scalar load comes from
	logic [1:0] lane_sel;

	assign lane_sel = offset[3:2];

	for (genvar j = 0; j < `WB_HW_LANES; j++) begin : g_lane
		logic [31:0] word;
		logic [7:0]  byte_val;
		logic [15:0] half_val;

		assign word     = raw[j][31:0];
		assign byte_val = word[offset[1:0]*8 +: 8];
		// Halfword picked by offset bit 1 only
		assign half_val = offset[1] ? word[31:16] : word[15:0];

		assign byte_s[j] = {{PAD8{byte_val[7]}}, byte_val};
		assign byte_u[j] = {{PAD8{1'b0}}, byte_val};
		assign half_s[j] = {{PAD16{half_val[15]}}, half_val};
		assign half_u[j] = {{PAD16{1'b0}}, half_val};
		assign word_v[j] = `WB_REG_BITS'(word);
	end

	always_comb begin
		formatted = '0;
		case (opcode)
			// Scalar loads land in lane 0
			LOAD_8:      formatted[0] = byte_s[lane_sel];
			LOAD_16:     formatted[0] = half_s[lane_sel];
			LOAD_32:     formatted[0] = word_v[lane_sel];
			LOAD_8_U:    formatted[0] = byte_u[lane_sel];
			LOAD_16_U:   formatted[0] = half_u[lane_sel];

			// Vector loads
			LOAD_V_8:    formatted = byte_s;
			LOAD_V_16:   formatted = half_s;
			LOAD_V_32:   formatted = word_v;
			LOAD_V_8_U:  formatted = byte_u;
			LOAD_V_16_U: formatted = half_u;

			default:     formatted = '0;
		endcase
	end

endmodule

// File: source/wb_arbiter.sv
`timescale 1ns/1ps
`include "wb_params.svh"

module wb_arbiter import wb_pkg::*; (
	input  logic      clk,
	input  logic      reset,
	input  pipe_vec_t pending,
	output logic      grant_valid,
	output pipe_vec_t grant_oh,
	output pipe_id_t  grant_idx
);

	// Highest priority pipe for the current cycle
	pipe_id_t rr_ptr;

	// First pending pipe at or after the pointer
	always_comb begin : pick_first
		int cand;
		grant_valid = 1'b0;
		grant_idx   = PIPE_FP;
		for (int i = 0; i < `WB_NUM_PIPES; i++) begin
			cand = (int'(rr_ptr) + i) % `WB_NUM_PIPES;
			if (!grant_valid && pending[cand]) begin
				grant_valid = 1'b1;
				grant_idx   = pipe_id_t'(cand);
			end
		end
	end

	// One-hot form feeds the FIFO dequeue enables
	assign grant_oh = grant_valid ? (pipe_vec_t'(1) << grant_idx) : '0;

	// Granted pipe drops to lowest priority
	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			rr_ptr <= PIPE_FP;
		else if (grant_valid)
			rr_ptr <= pipe_id_t'((int'(grant_idx) + 1) % `WB_NUM_PIPES);
	end

endmodule

// File: source/wb_output_stage.sv
`timescale 1ns/1ps
`include "wb_params.svh"

module wb_output_stage import wb_pkg::*; (
	input  logic        clk,
	input  logic        reset,
	input  logic        grant_valid,
	input  pipe_id_t    grant_idx,
	input  wb_request_t fp_head,
	input  wb_request_t int_head,
	input  wb_request_t spm_head,
	input  wb_request_t mem_head,
	input  lane_data_t  spm_loaded,
	input  lane_data_t  mem_loaded,
	output logic        wb_valid,
	output thread_id_t  wb_thread_id,
	output wb_result_t  wb_result
);

	wb_request_t sel_req;
	lane_data_t  sel_data;
	byte_en_t    byte_en;
	wb_result_t  result_next;
	logic        write_reg;

	// Granted head, loads take the formatted value
	always_comb begin
		case (grant_idx)
			PIPE_FP: begin
				sel_req  = fp_head;
				sel_data = fp_head.result;
			end
			PIPE_INT: begin
				sel_req  = int_head;
				sel_data = int_head.result;
			end
			PIPE_SPM: begin
				sel_req  = spm_head;
				sel_data = spm_loaded;
			end
			default: begin
				sel_req  = mem_head;
				sel_data = mem_loaded;
			end
		endcase
	end

	// Move-immediate variants write only part of the register
	always_comb begin
		case (sel_req.opcode)
			MOVEI:   byte_en = 4'b1111;
			MOVEI_L: byte_en = 4'b0011;
			MOVEI_H: byte_en = 4'b1100;
			default: byte_en = {`WB_BYTES_PER_REG{1'b1}};
		endcase
	end

	always_comb begin
		result_next.pc          = sel_req.pc;
		result_next.destination = sel_req.destination;
		result_next.is_scalar   = !sel_req.is_destination_vector;
		result_next.lane_mask   = sel_req.lane_mask;
		result_next.byte_enable = byte_en;
		result_next.data        = sel_data;
	end

	// Requests without a destination are dropped here
	assign write_reg = grant_valid && sel_req.has_destination;

	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			wb_valid <= 1'b0;
		else
			wb_valid <= write_reg;
	end

	always_ff @(posedge clk) begin
		if (write_reg) begin
			wb_result    <= result_next;
			wb_thread_id <= sel_req.thread_id;
		end
	end

endmodule

// File: source/wb_params.svh
`ifndef WB_PARAMS_SVH
`define WB_PARAMS_SVH

// Execution pipes feeding the writeback stage
`define WB_NUM_PIPES        4

// Register file geometry
`define WB_HW_LANES         4
`define WB_REG_BITS         32
`define WB_BYTES_PER_REG    4
`define WB_REG_ADDR_BITS    6

// Thread and fetch geometry
`define WB_THREADS          4
`define WB_PC_BITS          32

// Load address offset, low 2 bits pick the byte, upper 2 bits pick the lane
`define WB_OFFSET_BITS      4

// Request FIFO sizing
`define WB_FIFO_DEPTH       8
// Instructions still in flight once the scheduler sees almost-full
`define WB_FIFO_SLACK       4

`endif

// File: source/wb_pkg.sv
`include "wb_params.svh"

package wb_pkg;

	// FIFO index doubles as the source pipe
	typedef enum logic [$clog2(`WB_NUM_PIPES)-1:0] {
		PIPE_FP  = 0,
		PIPE_INT = 1,
		PIPE_SPM = 2,
		PIPE_MEM = 3
	} pipe_id_t;

	typedef logic [`WB_NUM_PIPES-1:0]                      pipe_vec_t;
	typedef logic [`WB_HW_LANES-1:0][`WB_REG_BITS-1:0]     lane_data_t;
	typedef logic [`WB_HW_LANES-1:0]                       lane_mask_t;
	typedef logic [`WB_BYTES_PER_REG-1:0]                  byte_en_t;
	typedef logic [$clog2(`WB_THREADS)-1:0]                thread_id_t;
	typedef logic [`WB_REG_ADDR_BITS-1:0]                  reg_addr_t;
	typedef logic [`WB_OFFSET_BITS-1:0]                    load_offset_t;

	typedef enum logic [3:0] {
		LOAD_8,
		LOAD_16,
		LOAD_32,
		LOAD_8_U,
		LOAD_16_U,
		LOAD_V_8,
		LOAD_V_16,
		LOAD_V_32,
		LOAD_V_8_U,
		LOAD_V_16_U,
		MOVEI,
		MOVEI_L,
		MOVEI_H,
		OP_ALU
	} wb_opcode_t;

	// One completed instruction as delivered by an execution pipe
	typedef struct packed {
		logic [`WB_PC_BITS-1:0] pc;
		thread_id_t             thread_id;
		lane_data_t             result;
		lane_mask_t             lane_mask;
		load_offset_t           offset;
		reg_addr_t              destination;
		logic                   has_destination;
		logic                   is_destination_vector;
		wb_opcode_t             opcode;
	} wb_request_t;

	// Register file write
	typedef struct packed {
		logic [`WB_PC_BITS-1:0] pc;
		reg_addr_t              destination;
		logic                   is_scalar;
		lane_mask_t             lane_mask;
		byte_en_t               byte_enable;
		lane_data_t             data;
	} wb_result_t;

endpackage

// File: source/wb_request_fifo.sv
`timescale 1ns/1ps
`include "wb_params.svh"

module wb_request_fifo import wb_pkg::*; #(
	parameter int DEPTH = `WB_FIFO_DEPTH,
	parameter int SLACK = `WB_FIFO_SLACK
) (
	input  logic        clk,
	input  logic        reset,
	input  logic        push,
	input  wb_request_t push_req,
	input  logic        pop,
	output wb_request_t head,
	output logic        empty,
	output logic        almost_full
);

	localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_BITS = $clog2(DEPTH + 1);
	localparam int AF_LEVEL = DEPTH - SLACK;

	wb_request_t         entries [DEPTH];
	logic [PTR_BITS-1:0] rd_ptr;
	logic [PTR_BITS-1:0] wr_ptr;
	logic [CNT_BITS-1:0] count;
	logic                do_pop;

	// Wrapping pointer increment for any DEPTH
	function automatic logic [PTR_BITS-1:0] ptr_inc(input logic [PTR_BITS-1:0] ptr);
		if (ptr == PTR_BITS'(DEPTH - 1))
			return '0;
		return ptr + 1'b1;
	endfunction

	// Pop on an empty FIFO is ignored
	assign do_pop = pop && !empty;

	assign head        = entries[rd_ptr];
	assign empty       = (count == '0);
	assign almost_full = (count >= CNT_BITS'(AF_LEVEL));

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)
				wr_ptr <= ptr_inc(wr_ptr);
			if (do_pop)
				rd_ptr <= ptr_inc(rd_ptr);
			case ({push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Storage
	always_ff @(posedge clk) begin
		if (push)
			entries[wr_ptr] <= push_req;
	end

endmodule

// File: source/writeback_top.sv
`timescale 1ns/1ps
`include "wb_params.svh"

module writeback_top import wb_pkg::*; (
	input  logic        clk,
	input  logic        reset,

	// Execution pipe results
	input  logic        fp_valid,
	input  wb_request_t fp_req,
	input  logic        int_valid,
	input  wb_request_t int_req,
	input  logic        spm_valid,
	input  wb_request_t spm_req,
	input  logic        mem_valid,
	input  wb_request_t mem_req,

	// Back-pressure toward the scheduler
	output pipe_vec_t   wb_fifo_full,

	// Register file write
	output logic        wb_valid,
	output thread_id_t  wb_thread_id,
	output wb_result_t  wb_result
);

	// Bit i belongs to pipe_id_t value i
	pipe_vec_t   push_vec;
	wb_request_t push_req [`WB_NUM_PIPES];
	wb_request_t fifo_head [`WB_NUM_PIPES];
	pipe_vec_t   fifo_empty;
	pipe_vec_t   pending;

	logic        grant_valid;
	pipe_vec_t   grant_oh;
	pipe_id_t    grant_idx;

	lane_data_t  spm_loaded;
	lane_data_t  mem_loaded;

	assign push_vec = {mem_valid, spm_valid, int_valid, fp_valid};

	assign push_req[PIPE_FP]  = fp_req;
	assign push_req[PIPE_INT] = int_req;
	assign push_req[PIPE_SPM] = spm_req;
	assign push_req[PIPE_MEM] = mem_req;

	for (genvar i = 0; i < `WB_NUM_PIPES; i++) begin : g_fifo
		wb_request_fifo fifo_i (
			.clk         (clk),
			.reset       (reset),
			.push        (push_vec[i]),
			.push_req    (push_req[i]),
			.pop         (grant_oh[i]),
			.head        (fifo_head[i]),
			.empty       (fifo_empty[i]),
			.almost_full (wb_fifo_full[i])
		);
	end

	assign pending = ~fifo_empty;

	wb_arbiter arbiter_i (
		.clk         (clk),
		.reset       (reset),
		.pending     (pending),
		.grant_valid (grant_valid),
		.grant_oh    (grant_oh),
		.grant_idx   (grant_idx)
	);

	// Load formatting on the two memory pipes
	load_formatter spm_fmt_i (
		.opcode    (fifo_head[PIPE_SPM].opcode),
		.offset    (fifo_head[PIPE_SPM].offset),
		.raw       (fifo_head[PIPE_SPM].result),
		.formatted (spm_loaded)
	);

	load_formatter mem_fmt_i (
		.opcode    (fifo_head[PIPE_MEM].opcode),
		.offset    (fifo_head[PIPE_MEM].offset),
		.raw       (fifo_head[PIPE_MEM].result),
		.formatted (mem_loaded)
	);

	wb_output_stage out_i (
		.clk          (clk),
		.reset        (reset),
		.grant_valid  (grant_valid),
		.grant_idx    (grant_idx),
		.fp_head      (fifo_head[PIPE_FP]),
		.int_head     (fifo_head[PIPE_INT]),
		.spm_head     (fifo_head[PIPE_SPM]),
		.mem_head     (fifo_head[PIPE_MEM]),
		.spm_loaded   (spm_loaded),
		.mem_loaded   (mem_loaded),
		.wb_valid     (wb_valid),
		.wb_thread_id (wb_thread_id),
		.wb_result    (wb_result)
	);

endmodule

// File: tb.f
+incdir+source
source/wb_pkg.sv
source/wb_request_fifo.sv
source/wb_arbiter.sv
source/load_formatter.sv
source/wb_output_stage.sv
source/writeback_top.sv
dv/wb_tb.sv
